/* common/cart_pkg.sv */
// Shared widths, header offsets, product code lists and the cheat code layout for the cart loader
package cart_pkg;

	localparam int ADDR_W = 25; // Download address width

	////////////////////////////////////////
	// Cartridge header byte addresses
	////////////////////////////////////////
	localparam int unsigned HDR_REGION_ADDR    = 'h1F0;
	localparam int unsigned HDR_REGION2_ADDR   = 'h1F2;
	localparam int unsigned HDR_END_ADDR       = 'h200; // Header fully written
	localparam int unsigned PRODUCT_ADDR_FIRST = 'h182; // High byte only
	localparam int unsigned PRODUCT_ADDR_LAST  = 'h18A; // Low byte only
	localparam int unsigned PRODUCT_CHECK_ADDR = 'h18C;

	typedef logic [63:0] product_code_t; // Eight ASCII characters

	// Console region encoding
	localparam logic [1:0] REGION_JP = 2'd0;
	localparam logic [1:0] REGION_US = 2'd1;
	localparam logic [1:0] REGION_EU = 2'd2;

	localparam logic [7:0] CODE_INDEX = 8'hFF; // Cheat stream download index

	////////////////////////////////////////
	// Product codes needing special handling
	////////////////////////////////////////
	localparam product_code_t SRAM_CODES [5] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 "
	};
	localparam product_code_t EEPROM_CODES [9] = '{
		"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
		"00004076", "T-12046 ", "T-12053 ", "G-4524  "
	};
	localparam product_code_t SVP_CODES [2] = '{"MK-1229 ", "G-7001  "}; // Needs SVP, no backup
	localparam product_code_t FMBUSY_CODES [3] = '{"T-35036 ", "T-25073 ", "MK-1137-"};

	// Cheat code, filled as half-word slots and read as big endian fields
	typedef union packed {
		logic [7:0][15:0] slot;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} field;
	} gg_code_u;

endpackage

/* logic/download_pacer.sv */
// Splits the host download into cart and cheat streams and paces ROM writes toward both memories
`timescale 1ns/10ps

module download_pacer #(
	parameter int ADDR_W = cart_pkg::ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic              ioctl_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  logic              sdrom_wrack,
	input  logic              ddrom_wrack,
	output logic              cart_load,
	output logic              code_load,
	output logic              ioctl_wait,
	output logic              rom_wr,
	output logic [ADDR_W-1:0] rom_size
);

	logic code_index;
	logic old_load;

	assign code_index = (ioctl_index == cart_pkg::CODE_INDEX);
	assign cart_load  = ioctl_download & ~code_index;
	assign code_load  = ioctl_download & code_index;

	// Each write flips rom_wr, memories echo it back when done
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ioctl_wait <= 1'b0;
			rom_wr     <= 1'b0;
			old_load   <= 1'b0;
		end else begin
			old_load <= cart_load;
			if (cart_load && ioctl_wr) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;
			end else if (ioctl_wait && (rom_wr == sdrom_wrack) && (rom_wr == ddrom_wrack)) begin
				ioctl_wait <= 1'b0; // Both memories caught up
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (old_load && !cart_load) rom_size <= ioctl_addr; // Last address of the image
	end

	// Host must honour the wait before the next ROM word
	a_no_write_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait |-> !(cart_load && ioctl_wr));

endmodule

/* logic/cart_header_scan.sv */
// Watches cart header writes for region letters and the product code, and raises quirk flags
`timescale 1ns/10ps

module cart_header_scan #(
	parameter int ADDR_W = cart_pkg::ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              cart_load,
	input  logic              ioctl_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]       ioctl_data,
	output logic              hdr_j,
	output logic              hdr_u,
	output logic              hdr_e,
	output logic              hdr_ready,
	output logic              sram_quirk,
	output logic              eeprom_quirk,
	output logic              svp_quirk,
	output logic              fmbusy_quirk
);

	logic                    old_load;
	logic                    hdr_wr;
	logic [7:0]              lo_byte;
	logic [7:0]              hi_byte;
	logic [3:0]              hrgn;
	cart_pkg::product_code_t cart_id;
	logic                    sram_hit;
	logic                    eeprom_hit;
	logic                    svp_hit;
	logic                    fmbusy_hit;

	assign hdr_wr  = cart_load & ioctl_wr;
	assign lo_byte = ioctl_data[7:0];
	assign hi_byte = ioctl_data[15:8];
	assign hrgn    = lo_byte[3:0] - 4'd7; // 'A'..'F' folded onto 10..15

	////////////////////////////////////////
	// Region flags
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready <= 1'b0;
			old_load  <= 1'b0;
		end else begin
			old_load <= cart_load;
			if (!old_load && cart_load) {hdr_j, hdr_u, hdr_e} <= 3'b000;
			if (old_load && !cart_load) hdr_ready <= 1'b0;

			if (hdr_wr) begin
				if (ioctl_addr == ADDR_W'(cart_pkg::HDR_REGION_ADDR)) begin
					if (lo_byte == "J") hdr_j <= 1'b1;
					else if (lo_byte == "U") hdr_u <= 1'b1;
					else if (lo_byte == "E") hdr_e <= 1'b1;
					else if (lo_byte >= "0" && lo_byte <= "9")
						{hdr_e, hdr_u, hdr_j} <= {lo_byte[3], lo_byte[2], lo_byte[0]};
					else if (lo_byte >= "A" && lo_byte <= "F")
						{hdr_e, hdr_u, hdr_j} <= {hrgn[3], hrgn[2], hrgn[0]};
				end
				if (ioctl_addr == ADDR_W'(cart_pkg::HDR_REGION2_ADDR)) begin
					if (lo_byte == "J") hdr_j <= 1'b1; // Letters only here
					else if (lo_byte == "U") hdr_u <= 1'b1;
					else if (lo_byte == "E") hdr_e <= 1'b1;
				end
				if (ioctl_addr == ADDR_W'(cart_pkg::HDR_REGION_ADDR)) begin
					if (hi_byte == "J") hdr_j <= 1'b1;
					else if (hi_byte == "U") hdr_u <= 1'b1;
					else if (hi_byte == "E") hdr_e <= 1'b1;
				end
				if (ioctl_addr == ADDR_W'(cart_pkg::HDR_END_ADDR)) hdr_ready <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Product code, stored as it reads
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (ioctl_addr == ADDR_W'(cart_pkg::PRODUCT_ADDR_FIRST))
				cart_id[63:56] <= hi_byte;
			if (ioctl_addr == ADDR_W'(cart_pkg::PRODUCT_ADDR_FIRST + 2))
				cart_id[55:40] <= {lo_byte, hi_byte};
			if (ioctl_addr == ADDR_W'(cart_pkg::PRODUCT_ADDR_FIRST + 4))
				cart_id[39:24] <= {lo_byte, hi_byte};
			if (ioctl_addr == ADDR_W'(cart_pkg::PRODUCT_ADDR_FIRST + 6))
				cart_id[23:8] <= {lo_byte, hi_byte};
			if (ioctl_addr == ADDR_W'(cart_pkg::PRODUCT_ADDR_LAST))
				cart_id[7:0] <= lo_byte;
		end
	end

	always_comb begin
		sram_hit   = 1'b0;
		eeprom_hit = 1'b0;
		svp_hit    = 1'b0;
		fmbusy_hit = 1'b0;
		for (int i = 0; i < $size(cart_pkg::SRAM_CODES); i++)
			if (cart_id == cart_pkg::SRAM_CODES[i]) sram_hit = 1'b1;
		for (int i = 0; i < $size(cart_pkg::EEPROM_CODES); i++)
			if (cart_id == cart_pkg::EEPROM_CODES[i]) eeprom_hit = 1'b1;
		for (int i = 0; i < $size(cart_pkg::SVP_CODES); i++)
			if (cart_id == cart_pkg::SVP_CODES[i]) svp_hit = 1'b1;
		for (int i = 0; i < $size(cart_pkg::FMBUSY_CODES); i++)
			if (cart_id == cart_pkg::FMBUSY_CODES[i]) fmbusy_hit = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= 4'b0000;
		end else begin
			if (!old_load && cart_load)
				{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= 4'b0000;
			if (hdr_wr && ioctl_addr == ADDR_W'(cart_pkg::PRODUCT_CHECK_ADDR))
				{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk}
					<= {sram_hit, eeprom_hit, svp_hit, fmbusy_hit};
		end
	end

endmodule

/* logic/region_select.sv */
// Picks the console region once the header is in, from the flags or from the download index
`timescale 1ns/10ps

module region_select (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       hdr_ready,
	input  logic       hdr_j,
	input  logic       hdr_u,
	input  logic       hdr_e,
	input  logic       auto_region_off,
	input  logic       manual_region,
	input  logic [1:0] region_priority,
	input  logic [7:0] ioctl_index,
	output logic [1:0] region_req,
	output logic       region_set
);

	logic old_ready;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			region_set <= 1'b0;
			old_ready  <= 1'b0;
		end else begin
			old_ready <= hdr_ready;
			if (!auto_region_off && !old_ready && hdr_ready) begin
				if (manual_region) begin
					region_set <= |ioctl_index; // Region comes from the file entry
					region_req <= ioctl_index[7:6];
				end else begin
					region_set <= 1'b1;
					case (region_priority)
						2'd0: if (hdr_u) region_req <= cart_pkg::REGION_US; // US>EU>JP
							else if (hdr_e) region_req <= cart_pkg::REGION_EU;
							else if (hdr_j) region_req <= cart_pkg::REGION_JP;
							else region_req <= cart_pkg::REGION_US;
						2'd1: if (hdr_e) region_req <= cart_pkg::REGION_EU; // EU>US>JP
							else if (hdr_u) region_req <= cart_pkg::REGION_US;
							else if (hdr_j) region_req <= cart_pkg::REGION_JP;
							else region_req <= cart_pkg::REGION_EU;
						2'd2: if (hdr_u) region_req <= cart_pkg::REGION_US; // US>JP>EU
							else if (hdr_j) region_req <= cart_pkg::REGION_JP;
							else if (hdr_e) region_req <= cart_pkg::REGION_EU;
							else region_req <= cart_pkg::REGION_US;
						default: if (hdr_j) region_req <= cart_pkg::REGION_JP; // JP>US>EU
							else if (hdr_u) region_req <= cart_pkg::REGION_US;
							else if (hdr_e) region_req <= cart_pkg::REGION_EU;
							else region_req <= cart_pkg::REGION_JP;
					endcase
				end
			end
			if (old_ready && !hdr_ready) region_set <= 1'b0; // Load finished
		end
	end

endmodule

/* logic/cheat_code_loader.sv */
// Builds one cheat code from eight half-word writes of the cheat stream and strobes it out
`timescale 1ns/10ps

module cheat_code_loader (
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               code_load,
	input  logic               ioctl_wr,
	input  logic [3:0]         ioctl_addr,
	input  logic [15:0]        ioctl_data,
	output cart_pkg::gg_code_u gg_code,
	output logic               gg_strobe,
	output logic               gg_reset
);

	logic       code_wr;
	logic [2:0] slot_sel;

	assign code_wr = code_load & ioctl_wr & ~ioctl_addr[0];

	// Bottom half-word of each field arrives first
	assign slot_sel = {~ioctl_addr[3:2], ioctl_addr[1]};

	always_ff @(posedge clk_sys) begin
		if (code_wr) gg_code.slot[slot_sel] <= ioctl_data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_strobe <= 1'b0;
			gg_reset  <= 1'b0;
		end else begin
			gg_strobe <= code_wr && (ioctl_addr == 4'd14); // Replace top word completes it
			gg_reset  <= code_wr && (ioctl_addr == 4'd0);
		end
	end

	a_strobe_single: assert property (@(posedge clk_sys) disable iff (RESET)
		gg_strobe |=> !gg_strobe);

endmodule

/* backup/bram_sequencer.sv */
// Runs the backup RAM sector loop, asking the storage host to read or write each sector
`timescale 1ns/10ps

module bram_sequencer #(
	parameter int SECTOR_BITS = 7
) (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        cart_load,
	input  logic        svp_quirk,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        sd_ack,
	input  logic [63:0] img_size,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_busy,
	output logic        bk_loading
);

	logic bk_ena;
	logic old_load_cart;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic req_edge;
	logic cart_done;

	assign req_edge  = (~old_load & bk_load) | (~old_save & bk_save);
	assign cart_done = old_load_cart & ~cart_load & |img_size;

	////////////////////////////////////////
	// Backup enable
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena <= 1'b0;
		end else begin
			if (!old_load_cart && cart_load) bk_ena <= 1'b0;
			// Save file is mounted by the end of the download
			if (cart_load && img_mounted && !img_readonly && !svp_quirk) bk_ena <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Sector loop
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load_cart <= 1'b0;
			old_load      <= 1'b0;
			old_save      <= 1'b0;
			old_ack       <= 1'b0;
			sd_rd         <= 1'b0;
			sd_wr         <= 1'b0;
			bk_busy       <= 1'b0;
			bk_loading    <= 1'b0;
		end else begin
			old_load_cart <= cart_load;
			old_load      <= bk_load;
			old_save      <= bk_save;
			old_ack       <= sd_ack;

			if (!old_ack && sd_ack) {sd_rd, sd_wr} <= 2'b00; // Host took the request

			if (!bk_busy) begin
				if (bk_ena && req_edge) begin
					bk_busy    <= 1'b1;
					bk_loading <= bk_load;
					sd_lba     <= 32'd0;
					sd_rd      <= bk_load;
					sd_wr      <= ~bk_load;
				end
				if (bk_ena && cart_done) begin // Restore the save after a new cart
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= 32'd0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				if (&sd_lba[SECTOR_BITS-1:0]) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr));

endmodule

/* logic/cart_loader_top.sv */
// Top of the cartridge loading path, ties the pacer, header scan, region, cheat and backup blocks
`timescale 1ns/10ps

module cart_loader_top #(
	parameter int ADDR_W      = cart_pkg::ADDR_W,
	parameter int SECTOR_BITS = 7
) (
	input  logic               clk_sys,
	input  logic               RESET,
	// Host download
	input  logic               ioctl_download,
	input  logic [7:0]         ioctl_index,
	input  logic               ioctl_wr,
	input  logic [ADDR_W-1:0]  ioctl_addr,
	input  logic [15:0]        ioctl_data,
	output logic               ioctl_wait,
	// ROM memories
	output logic               rom_wr,
	input  logic               sdrom_wrack,
	input  logic               ddrom_wrack,
	output logic [ADDR_W-1:0]  rom_size,
	// Region options
	input  logic               auto_region_off,
	input  logic               manual_region,
	input  logic [1:0]         region_priority,
	output logic [1:0]         region_req,
	output logic               region_set,
	// Cart quirks
	output logic               sram_quirk,
	output logic               eeprom_quirk,
	output logic               svp_quirk,
	output logic               fmbusy_quirk,
	// Cheats
	output cart_pkg::gg_code_u gg_code,
	output logic               gg_strobe,
	output logic               gg_reset,
	// Backup RAM storage host
	input  logic               img_mounted,
	input  logic               img_readonly,
	input  logic [63:0]        img_size,
	input  logic               bk_load,
	input  logic               bk_save,
	input  logic               sd_ack,
	output logic [31:0]        sd_lba,
	output logic               sd_rd,
	output logic               sd_wr,
	output logic               bk_busy,
	output logic               bk_loading
);

	logic cart_load;
	logic code_load;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	download_pacer #(.ADDR_W(ADDR_W)) u_pacer (
		.clk_sys(clk_sys), .RESET(RESET),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.sdrom_wrack(sdrom_wrack), .ddrom_wrack(ddrom_wrack),
		.cart_load(cart_load), .code_load(code_load),
		.ioctl_wait(ioctl_wait), .rom_wr(rom_wr), .rom_size(rom_size)
	);

	cart_header_scan #(.ADDR_W(ADDR_W)) u_hdr (
		.clk_sys(clk_sys), .RESET(RESET), .cart_load(cart_load),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e), .hdr_ready(hdr_ready),
		.sram_quirk(sram_quirk), .eeprom_quirk(eeprom_quirk),
		.svp_quirk(svp_quirk), .fmbusy_quirk(fmbusy_quirk)
	);

	region_select u_region (
		.clk_sys(clk_sys), .RESET(RESET), .hdr_ready(hdr_ready),
		.hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e),
		.auto_region_off(auto_region_off), .manual_region(manual_region),
		.region_priority(region_priority), .ioctl_index(ioctl_index),
		.region_req(region_req), .region_set(region_set)
	);

	cheat_code_loader u_cheat (
		.clk_sys(clk_sys), .RESET(RESET), .code_load(code_load),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr[3:0]), .ioctl_data(ioctl_data),
		.gg_code(gg_code), .gg_strobe(gg_strobe), .gg_reset(gg_reset)
	);

	bram_sequencer #(.SECTOR_BITS(SECTOR_BITS)) u_bram (
		.clk_sys(clk_sys), .RESET(RESET), .cart_load(cart_load),
		.svp_quirk(svp_quirk), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.bk_load(bk_load), .bk_save(bk_save), .sd_ack(sd_ack), .img_size(img_size),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_busy(bk_busy), .bk_loading(bk_loading)
	);

endmodule

/* verif/cart_loader_tasks.svh */
// Host driver tasks, expected value functions and directed tests, included into the testbench module

task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
	$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
	value_errors++;
endtask

////////////////////////////////////////
// Expected values
////////////////////////////////////////
function automatic logic [2:0] header_flags(input logic [7:0] ch); // Returns {J, U, E}
	logic [7:0] v;
	v = ch - 8'd7;
	if (ch == "J") return 3'b100;
	if (ch == "U") return 3'b010;
	if (ch == "E") return 3'b001;
	if (ch >= "0" && ch <= "9") return {ch[0], ch[2], ch[3]};
	if (ch >= "A" && ch <= "F") return {v[0], v[2], v[3]}; // Hex letter folded down by 7
	return 3'b000;
endfunction

function automatic logic [1:0] expected_region(input logic [1:0] prio, input logic [2:0] jue);
	logic [1:0] order [3];
	logic       hit;
	case (prio)
		2'd0:    order = '{cart_pkg::REGION_US, cart_pkg::REGION_EU, cart_pkg::REGION_JP};
		2'd1:    order = '{cart_pkg::REGION_EU, cart_pkg::REGION_US, cart_pkg::REGION_JP};
		2'd2:    order = '{cart_pkg::REGION_US, cart_pkg::REGION_JP, cart_pkg::REGION_EU};
		default: order = '{cart_pkg::REGION_JP, cart_pkg::REGION_US, cart_pkg::REGION_EU};
	endcase
	for (int i = 0; i < 3; i++) begin
		case (order[i])
			cart_pkg::REGION_JP: hit = jue[2];
			cart_pkg::REGION_US: hit = jue[1];
			default:             hit = jue[0];
		endcase
		if (hit) return order[i];
	end
	return order[0]; // First choice is the default when no flag is set
endfunction

// Character n of the code sits at byte 0x183 + n with even bytes in the low half
function automatic logic [7:0] product_char(input logic [63:0] code, input int k);
	if (k < 0 || k > 7) return 8'h20;
	return code[63 - 8 * k -: 8];
endfunction

////////////////////////////////////////
// Host side
////////////////////////////////////////
task automatic begin_download(input logic [7:0] index);
	ioctl_index    <= index;
	ioctl_download <= 1'b1;
	repeat (2) @(posedge clk_sys);
endtask

task automatic end_download();
	ioctl_download <= 1'b0;
	repeat (3) @(posedge clk_sys);
endtask

// One word, then hold off until ioctl_wait has fallen
task automatic host_write(input logic [cart_pkg::ADDR_W-1:0] addr, input logic [15:0] data);
	ioctl_addr <= addr;
	ioctl_data <= data;
	ioctl_wr   <= 1'b1;
	@(posedge clk_sys);
	ioctl_wr <= 1'b0;
	do @(posedge clk_sys); while (ioctl_wait);
endtask

task automatic run_header(input logic [7:0] index, input logic [15:0] region_word);
	begin_download(index);
	host_write(25'h1F0, region_word);
	host_write(25'h200, 16'h0000); // Header complete
	@(posedge clk_sys);
endtask

task automatic region_case(input logic [1:0] prio, input logic [7:0] ch);
	logic [1:0] exp;
	exp = expected_region(prio, header_flags(ch));
	region_priority <= prio;
	run_header(8'h00, {8'h20, ch});
	if (region_set !== 1'b1) report_mismatch("region_set", 64'(region_set), 64'd1);
	if (region_req !== exp) report_mismatch("region_req", 64'(region_req), 64'(exp));
	end_download();
	if (region_set !== 1'b0) report_mismatch("region_set", 64'(region_set), 64'd0);
endtask

task automatic wait_backup_done();
	while (!bk_busy) @(posedge clk_sys);
	while (bk_busy) @(posedge clk_sys);
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////
task automatic pace_rom_writes();
	int start_toggles;
	int start_waits;
	start_toggles = rom_toggles;
	start_waits   = wait_rises;
	begin_download(8'h00);
	for (int i = 0; i < 16; i++) host_write(25'(2 * i), 16'($urandom));
	if (rom_toggles - start_toggles != 16)
		report_mismatch("rom_wr toggles", 64'(rom_toggles - start_toggles), 64'd16);
	if (wait_rises - start_waits != 16)
		report_mismatch("ioctl_wait rises", 64'(wait_rises - start_waits), 64'd16);
	end_download();
	if (rom_size !== 25'd30) report_mismatch("rom_size", 64'(rom_size), 64'd30);
endtask

task automatic header_region_letters();
	for (int p = 0; p < 4; p++) begin
		region_case(2'(p), "E");
		region_case(2'(p), " "); // No region letter
	end
endtask

task automatic region_encodings();
	region_case(2'd0, "6");
	region_case(2'd1, "6");
	region_case(2'd0, "C");
	region_case(2'd1, "C");

	// Header says JP so only the index can give EU
	manual_region <= 1'b1;
	run_header(8'h80, 16'h204A);
	if (region_set !== 1'b1) report_mismatch("region_set", 64'(region_set), 64'd1);
	if (region_req !== 2'd2) report_mismatch("region_req", 64'(region_req), 64'd2);
	end_download();
	manual_region <= 1'b0;

	auto_region_off <= 1'b1;
	run_header(8'h00, 16'h2045);
	if (region_set !== 1'b0) report_mismatch("region_set", 64'(region_set), 64'd0);
	end_download();
	auto_region_off <= 1'b0;
endtask

// Leaves the download open so the caller can act before it ends
task automatic scan_product(input logic [63:0] code, input logic [3:0] exp_quirks);
	logic [7:0] lo_char;
	logic [7:0] hi_char;
	logic [3:0] got;
	begin_download(8'h00);
	for (int w = 0; w < 5; w++) begin
		lo_char = product_char(code, 2 * w - 1);
		hi_char = product_char(code, 2 * w);
		host_write(25'(32'h182 + 2 * w), {hi_char, lo_char});
	end
	host_write(25'h18C, 16'h0000);
	got = {sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk};
	if (got !== exp_quirks) report_mismatch("quirk flags", 64'(got), 64'(exp_quirks));
endtask

task automatic product_quirks();
	int rd_start;
	scan_product("T-81406 ", 4'b1000);
	end_download();

	rd_start = rd_lba.size();
	scan_product("MK-1229 ", 4'b0010);
	img_mounted <= 1'b1; // Save image arrives after the compare
	img_size    <= 64'h8000;
	repeat (2) @(posedge clk_sys);
	end_download();
	bk_load <= 1'b1;
	repeat (4) @(posedge clk_sys);
	bk_load <= 1'b0;
	repeat (12) @(posedge clk_sys);
	if (rd_lba.size() != rd_start)
		report_mismatch("sd_rd requests", 64'(rd_lba.size() - rd_start), 64'd0);
	if (bk_busy !== 1'b0) report_mismatch("bk_busy", 64'(bk_busy), 64'd0);
	img_mounted <= 1'b0;
	img_size    <= 64'd0;

	scan_product("MK-1215 ", 4'b0100);
	end_download();
	scan_product("T-35036 ", 4'b0001);
	end_download();

	scan_product("ZZ-99999", 4'b0000);
	end_download();
endtask

task automatic load_cheat_code();
	logic [15:0] half [8];
	int          toggles0;
	int          strobes0;
	int          resets0;
	toggles0 = rom_toggles;
	strobes0 = strobe_count;
	resets0  = reset_count;
	for (int k = 0; k < 8; k++) half[k] = 16'($urandom);
	begin_download(cart_pkg::CODE_INDEX);
	for (int k = 0; k < 8; k++) host_write(25'(2 * k), half[k]);
	repeat (2) @(posedge clk_sys);
	if (strobe_count - strobes0 != 1)
		report_mismatch("gg_strobe pulses", 64'(strobe_count - strobes0), 64'd1);
	if (reset_count - resets0 != 1)
		report_mismatch("gg_reset pulses", 64'(reset_count - resets0), 64'd1);
	if (gg_code.field.flags !== {half[1], half[0]}) // Low half of each field first
		report_mismatch("gg_code flags", 64'(gg_code.field.flags), 64'({half[1], half[0]}));
	if (gg_code.field.address !== {half[3], half[2]})
		report_mismatch("gg_code address", 64'(gg_code.field.address), 64'({half[3], half[2]}));
	if (gg_code.field.compare !== {half[5], half[4]})
		report_mismatch("gg_code compare", 64'(gg_code.field.compare), 64'({half[5], half[4]}));
	if (gg_code.field.replace !== {half[7], half[6]})
		report_mismatch("gg_code replace", 64'(gg_code.field.replace), 64'({half[7], half[6]}));
	if (rom_toggles != toggles0)
		report_mismatch("rom_wr toggles", 64'(rom_toggles - toggles0), 64'd0);
	end_download();
endtask

task automatic backup_load_save();
	int rd_start;
	int wr_start;
	rd_start    = rd_lba.size();
	img_mounted <= 1'b1;
	img_size    <= 64'h2000;
	begin_download(8'h00);
	host_write(25'h000, 16'h1234);
	end_download(); // Restore starts as the load ends
	wait_backup_done();
	if (rd_lba.size() - rd_start != 4)
		report_mismatch("sd_rd requests", 64'(rd_lba.size() - rd_start), 64'd4);
	for (int k = 0; k < 4 && rd_start + k < rd_lba.size(); k++)
		if (rd_lba[rd_start + k] !== 32'(k))
			report_mismatch("sd_lba", 64'(rd_lba[rd_start + k]), 64'(k));
	if (bk_loading !== 1'b0) report_mismatch("bk_loading", 64'(bk_loading), 64'd0);

	wr_start = wr_lba.size();
	bk_save <= 1'b1;
	wait_backup_done();
	bk_save <= 1'b0;
	if (wr_lba.size() - wr_start != 4)
		report_mismatch("sd_wr requests", 64'(wr_lba.size() - wr_start), 64'd4);
	for (int k = 0; k < 4 && wr_start + k < wr_lba.size(); k++)
		if (wr_lba[wr_start + k] !== 32'(k))
			report_mismatch("sd_lba", 64'(wr_lba[wr_start + k]), 64'(k));
	img_mounted <= 1'b0;
	img_size    <= 64'd0;
endtask

/* verif/cart_loader_tb.sv */
// Testbench for the cart loader top, with ROM ack and storage host models around the directed tests
`timescale 1ns/10ps

module cart_loader_tb;

	localparam int          ADDR_W      = cart_pkg::ADDR_W;
	localparam int          SECTOR_BITS = 2; // Four backup sectors
	localparam logic [31:0] RAND_SEED   = 32'h918a095b;
	// About 85 host writes of up to 12 cycles plus download gaps and two backup runs stay below 2000
	localparam int          TIMEOUT_CYCLES = 20000;

	logic               clk_sys;
	logic               RESET;
	logic               ioctl_download;
	logic [7:0]         ioctl_index;
	logic               ioctl_wr;
	logic [ADDR_W-1:0]  ioctl_addr;
	logic [15:0]        ioctl_data;
	logic               ioctl_wait;
	logic               rom_wr;
	logic               sdrom_wrack = 1'b0;
	logic               ddrom_wrack = 1'b0;
	logic [ADDR_W-1:0]  rom_size;
	logic               auto_region_off;
	logic               manual_region;
	logic [1:0]         region_priority;
	logic [1:0]         region_req;
	logic               region_set;
	logic               sram_quirk;
	logic               eeprom_quirk;
	logic               svp_quirk;
	logic               fmbusy_quirk;
	cart_pkg::gg_code_u gg_code;
	logic               gg_strobe;
	logic               gg_reset;
	logic               img_mounted;
	logic               img_readonly;
	logic [63:0]        img_size;
	logic               bk_load;
	logic               bk_save;
	logic               sd_ack = 1'b0;
	logic [31:0]        sd_lba;
	logic               sd_rd;
	logic               sd_wr;
	logic               bk_busy;
	logic               bk_loading;

	int          value_errors = 0;
	int          proto_errors = 0;
	int          cycle_count  = 0;
	int          rom_toggles  = 0;
	int          wait_rises   = 0;
	int          strobe_count = 0;
	int          reset_count  = 0;
	logic [31:0] rd_lba [$];  // sd_lba at each new read request
	logic [31:0] wr_lba [$];
	logic        prev_rom_wr = 1'b0;
	logic        prev_wait   = 1'b0;
	logic        prev_rd     = 1'b0;
	logic        prev_wr     = 1'b0;
	logic [2:0]  sd_delay;
	logic [2:0]  dd_delay;
	logic [1:0]  ack_left;

	cart_loader_top #(.ADDR_W(ADDR_W), .SECTOR_BITS(SECTOR_BITS)) uut (
		.clk_sys(clk_sys), .RESET(RESET),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wait(ioctl_wait),
		.rom_wr(rom_wr), .sdrom_wrack(sdrom_wrack), .ddrom_wrack(ddrom_wrack),
		.rom_size(rom_size),
		.auto_region_off(auto_region_off), .manual_region(manual_region),
		.region_priority(region_priority), .region_req(region_req), .region_set(region_set),
		.sram_quirk(sram_quirk), .eeprom_quirk(eeprom_quirk),
		.svp_quirk(svp_quirk), .fmbusy_quirk(fmbusy_quirk),
		.gg_code(gg_code), .gg_strobe(gg_strobe), .gg_reset(gg_reset),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .img_size(img_size),
		.bk_load(bk_load), .bk_save(bk_save), .sd_ack(sd_ack), .sd_lba(sd_lba),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .bk_busy(bk_busy), .bk_loading(bk_loading)
	);

	`include "cart_loader_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// ROM memories, each echoes rom_wr after 0 to 5 cycles
	////////////////////////////////////////
	always @(posedge clk_sys) begin
		if (RESET) begin
			sdrom_wrack <= 1'b0;
			sd_delay    <= 3'd0;
		end else if (sdrom_wrack == rom_wr) begin
			sd_delay <= 3'($urandom % 6);
		end else if (sd_delay == 3'd0) begin
			sdrom_wrack <= rom_wr;
		end else begin
			sd_delay <= sd_delay - 3'd1;
		end
	end

	always @(posedge clk_sys) begin
		if (RESET) begin
			ddrom_wrack <= 1'b0;
			dd_delay    <= 3'd0;
		end else if (ddrom_wrack == rom_wr) begin
			dd_delay <= 3'($urandom % 6);
		end else if (dd_delay == 3'd0) begin
			ddrom_wrack <= rom_wr;
		end else begin
			dd_delay <= dd_delay - 3'd1;
		end
	end

	// Storage host answers every sector request with a 3 cycle ack
	always @(posedge clk_sys) begin
		if (RESET) begin
			sd_ack   <= 1'b0;
			ack_left <= 2'd0;
		end else if (ack_left != 2'd0) begin
			ack_left <= ack_left - 2'd1;
			if (ack_left == 2'd1) sd_ack <= 1'b0;
		end else if ((sd_rd || sd_wr) && !sd_ack) begin
			sd_ack   <= 1'b1;
			ack_left <= 2'd3;
		end
	end

	////////////////////////////////////////
	// Monitors
	////////////////////////////////////////
	always @(posedge clk_sys) begin
		prev_rom_wr <= rom_wr;
		prev_wait   <= ioctl_wait;
		prev_rd     <= sd_rd;
		prev_wr     <= sd_wr;
		if (!RESET) begin
			if (rom_wr != prev_rom_wr) rom_toggles++;
			if (ioctl_wait && !prev_wait) wait_rises++;
			if (prev_wait && !ioctl_wait &&
					(sdrom_wrack != rom_wr || ddrom_wrack != rom_wr)) begin
				$display("ioctl_wait fell before both memories echoed rom_wr at cycle %0d",
					cycle_count);
				proto_errors++;
			end
			if (gg_strobe) strobe_count++;
			if (gg_reset) reset_count++;
			if (sd_rd && !prev_rd) rd_lba.push_back(sd_lba);
			if (sd_wr && !prev_wr) wr_lba.push_back(sd_lba);
			if (sd_rd && sd_wr) begin
				$display("sd_rd and sd_wr were high together at cycle %0d", cycle_count);
				proto_errors++;
			end
			if (sd_rd && !bk_loading) begin
				$display("sd_rd was raised while bk_loading was low at cycle %0d", cycle_count);
				proto_errors++;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles, a wait on the DUT never ended", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(RAND_SEED));
		RESET           <= 1'b1;
		ioctl_download  <= 1'b0;
		ioctl_index     <= 8'h00;
		ioctl_wr        <= 1'b0;
		ioctl_addr      <= '0;
		ioctl_data      <= 16'h0000;
		auto_region_off <= 1'b0;
		manual_region   <= 1'b0;
		region_priority <= 2'd0;
		img_mounted     <= 1'b0;
		img_readonly    <= 1'b0;
		img_size        <= 64'd0;
		bk_load         <= 1'b0;
		bk_save         <= 1'b0;
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(posedge clk_sys);

		pace_rom_writes();
		header_region_letters();
		region_encodings();
		product_quirks();
		load_cheat_code();
		backup_load_save();

		$display("Value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+verif
common/cart_pkg.sv
logic/download_pacer.sv
logic/cart_header_scan.sv
logic/region_select.sv
logic/cheat_code_loader.sv
backup/bram_sequencer.sv
logic/cart_loader_top.sv
verif/cart_loader_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the output for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cart_loader_tb -f compile.f \
	-Mdir obj_dir -o cart_loader_sim || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/cart_loader_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Test OK" && exit 0 || exit 1
